// ==== Bender.yml ====
package:
  name: itim

sources:
  - files:
      - src/itim_pkg.sv
      - src/itim_ram.sv
      - src/itim_fill.sv
      - src/itim_ctrl.sv
      - src/itim.sv
  - target: test
    files:
      - verif/imem_model.sv
      - verif/itim_tb.sv

// ==== project.f ====
src/itim_pkg.sv
src/itim_ram.sv
src/itim_fill.sv
src/itim_ctrl.sv
src/itim.sv
verif/imem_model.sv
verif/itim_tb.sv

// ==== src/itim.sv ====
`timescale 1ns/100ps

module itim
  import itim_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  fetch_req_t fetch_req,
  output fetch_rsp_t fetch_rsp,
  output imem_req_t  imem_req,
  input  imem_rsp_t  imem_rsp
);

  tag_wr_t tag_wr;
  line_wr_t line_wr;
  lock_wr_t lock_wr;
  logic [itim_depth-1:0] rd_index;
  logic [tag_bits-1:0] tag_rd;
  logic [line_bits-1:0] line_rd;
  logic lock_rd;
  fill_cmd_t fill_cmd;
  fill_rsp_t fill_rsp;

  itim_ctrl i_ctrl (
    .clk       (clk),
    .rst       (rst),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .tag_wr    (tag_wr),
    .line_wr   (line_wr),
    .lock_wr   (lock_wr),
    .rd_index  (rd_index),
    .tag_rd    (tag_rd),
    .line_rd   (line_rd),
    .lock_rd   (lock_rd),
    .fill_cmd  (fill_cmd),
    .fill_rsp  (fill_rsp)
  );

  itim_fill i_fill (
    .clk      (clk),
    .rst      (rst),
    .cmd      (fill_cmd),
    .rsp      (fill_rsp),
    .imem_req (imem_req),
    .imem_rsp (imem_rsp)
  );

  // tag, line and lock stores.
  itim_ram #(.data_width(tag_bits), .wr_t(tag_wr_t)) i_tag (
    .clk   (clk),
    .wr    (tag_wr),
    .raddr (rd_index),
    .rdata (tag_rd)
  );

  itim_ram #(.data_width(line_bits), .wr_t(line_wr_t)) i_line (
    .clk   (clk),
    .wr    (line_wr),
    .raddr (rd_index),
    .rdata (line_rd)
  );

  itim_ram #(.data_width(1), .wr_t(lock_wr_t)) i_lock (
    .clk   (clk),
    .wr    (lock_wr),
    .raddr (rd_index),
    .rdata (lock_rd)
  );

endmodule

// ==== src/itim_ctrl.sv ====
`timescale 1ns/100ps

module itim_ctrl
  import itim_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  fetch_req_t            fetch_req,
  output fetch_rsp_t            fetch_rsp,
  output tag_wr_t               tag_wr,
  output line_wr_t              line_wr,
  output lock_wr_t              lock_wr,
  output logic [itim_depth-1:0] rd_index,
  input  logic [tag_bits-1:0]   tag_rd,
  input  logic [line_bits-1:0]  line_rd,
  input  logic                  lock_rd,
  output fill_cmd_t             fill_cmd,
  input  fill_rsp_t             fill_rsp
);

  typedef enum logic [2:0] {
    st_lookup,
    st_miss,
    st_load,
    st_update,
    st_fence
  } state_t;

  state_t state;
  state_t state_n;

  // front register, valid marks a fetch and fence a fence request.
  fetch_req_t front;

  logic [itim_depth-1:0] fence_idx;
  logic fence_step;
  logic [line_bits-1:0] line_q;
  logic in_window;
  logic take_fetch;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // front stage.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign take_fetch = fetch_req.valid & ~fetch_req.fence;

  // arrays are read with the index of the request being captured.
  assign rd_index = take_fetch ? fetch_req.addr.fields.index : front.addr.fields.index;

  always_ff @(posedge clk) begin
    if (!rst) begin
      front <= '0;
    end else begin
      front.valid <= take_fetch;
      front.fence <= fetch_req.valid & fetch_req.fence;
      if (take_fetch) begin
        front.addr <= fetch_req.addr;
      end
    end
  end

  assign in_window = (front.addr.flat >= itim_base_addr) &&
                     (front.addr.flat < itim_top_addr);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machine.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    state_n = state;
    fetch_rsp = '0;
    fill_cmd = '0;
    fence_step = 1'b0;

    tag_wr.wen = 1'b0;
    tag_wr.waddr = front.addr.fields.index;
    tag_wr.wdata = front.addr.fields.tag;
    line_wr.wen = 1'b0;
    line_wr.waddr = front.addr.fields.index;
    line_wr.wdata = line_q;
    lock_wr.wen = 1'b0;
    lock_wr.waddr = front.addr.fields.index;
    lock_wr.wdata = 1'b1;

    case (state)
      st_lookup: begin
        if (front.fence) begin
          // line zero is cleared here, the rest in the fence state.
          lock_wr.wen = 1'b1;
          lock_wr.waddr = fence_idx;
          lock_wr.wdata = 1'b0;
          fence_step = 1'b1;
          state_n = st_fence;
        end else if (front.valid) begin
          if (!in_window) begin
            fill_cmd.start = 1'b1;
            fill_cmd.line = 1'b0;
            fill_cmd.addr = front.addr.flat;
            state_n = st_load;
          end else if (!lock_rd || (tag_rd != front.addr.fields.tag)) begin
            fill_cmd.start = 1'b1;
            fill_cmd.line = 1'b1;
            fill_cmd.addr = front.addr.flat;
            state_n = st_miss;
          end else begin
            fetch_rsp.ready = 1'b1;
            fetch_rsp.rdata = line_rd[32*front.addr.fields.word +: 32];
          end
        end
      end
      st_miss: begin
        if (fill_rsp.done) begin
          state_n = st_update;
        end
      end
      st_load: begin
        fetch_rsp.ready = fill_rsp.done;
        fetch_rsp.rdata = fill_rsp.word;
        if (fill_rsp.done) begin
          state_n = st_lookup;
        end
      end
      st_update: begin
        tag_wr.wen = 1'b1;
        line_wr.wen = 1'b1;
        lock_wr.wen = 1'b1;
        fetch_rsp.ready = 1'b1;
        fetch_rsp.rdata = line_q[32*front.addr.fields.word +: 32];
        state_n = st_lookup;
      end
      st_fence: begin
        lock_wr.wen = 1'b1;
        lock_wr.waddr = fence_idx;
        lock_wr.wdata = 1'b0;
        fence_step = 1'b1;
        if (fence_idx == '1) begin
          fetch_rsp.ready = 1'b1;
          state_n = st_lookup;
        end
      end
      default: begin
        state_n = st_lookup;
      end
    endcase
  end

  // fence_idx wraps back to zero after line 15.
  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= st_lookup;
      fence_idx <= '0;
    end else begin
      state <= state_n;
      if (fence_step) begin
        fence_idx <= fence_idx + 1'b1;
      end
    end
  end

  // filled line held for the update cycle.
  always_ff @(posedge clk) begin
    if ((state == st_miss) && fill_rsp.done) begin
      line_q <= fill_rsp.line;
    end
  end

endmodule

// ==== src/itim_fill.sv ====
`timescale 1ns/100ps

module itim_fill
  import itim_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  fill_cmd_t cmd,
  output fill_rsp_t rsp,
  output imem_req_t imem_req,
  input  imem_rsp_t imem_rsp
);

  logic busy;
  logic line_mode;
  logic [itim_width-1:0] cnt;
  logic [itim_width-1:0] last_cnt;
  logic [31:0] addr_q;
  logic [line_bits-1:0] line_q;
  logic [line_bits-1:0] line_c;
  logic last;

  assign last_cnt = line_mode ? itim_width'(words_per_line - 1) : '0;
  assign last = (cnt == last_cnt);

  // line buffer with the arriving word merged in.
  always_comb begin
    line_c = line_q;
    line_c[32*cnt +: 32] = imem_rsp.rdata;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy <= 1'b0;
      cnt <= '0;
    end else if (!busy) begin
      if (cmd.start) begin
        busy <= 1'b1;
        cnt <= '0;
      end
    end else if (imem_rsp.ready) begin
      cnt <= cnt + 1'b1;
      if (last) begin
        busy <= 1'b0;
      end
    end
  end

  // a line fetch starts at word zero of the line.
  always_ff @(posedge clk) begin
    if (!busy && cmd.start) begin
      line_mode <= cmd.line;
      if (cmd.line) begin
        addr_q <= {cmd.addr[31:itim_width+2], {(itim_width + 2){1'b0}}};
      end else begin
        addr_q <= cmd.addr;
      end
    end else if (busy && imem_rsp.ready) begin
      addr_q <= addr_q + 32'd4;
      line_q <= line_c;
    end
  end

  assign imem_req.valid = busy;
  assign imem_req.addr = addr_q;

  // done follows the memory ready of the last word in the same cycle.
  assign rsp.done = busy & imem_rsp.ready & last;
  assign rsp.word = imem_rsp.rdata;
  assign rsp.line = line_c;

endmodule

// ==== src/itim_pkg.sv ====
package itim_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // geometry of the direct-mapped store.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int itim_depth = 4;
  localparam int itim_width = 2;
  localparam int words_per_line = 2 ** itim_width;
  localparam int itim_lines = 2 ** itim_depth;
  localparam int line_bits = 32 * words_per_line;
  localparam int tag_bits = 32 - itim_depth - itim_width - 2;

  // cached window, top bound excluded.
  localparam logic [31:0] itim_base_addr = 32'h0000_1000;
  localparam logic [31:0] itim_top_addr = 32'h0000_2000;

  typedef struct packed {
    logic [tag_bits-1:0] tag;
    logic [itim_depth-1:0] index;
    logic [itim_width-1:0] word;
    logic [1:0] byte_off;
  } itim_addr_fields_t;

  typedef union packed {
    logic [31:0] flat;
    itim_addr_fields_t fields;
  } itim_addr_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fetch port and backing memory port.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic valid;
    logic fence;
    itim_addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    logic ready;
    logic [31:0] rdata;
  } fetch_rsp_t;

  typedef struct packed {
    logic valid;
    logic [31:0] addr;
  } imem_req_t;

  typedef struct packed {
    logic ready;
    logic [31:0] rdata;
  } imem_rsp_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // array write ports and the controller to fill engine link.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic wen;
    logic [itim_depth-1:0] waddr;
    logic [tag_bits-1:0] wdata;
  } tag_wr_t;

  typedef struct packed {
    logic wen;
    logic [itim_depth-1:0] waddr;
    logic [line_bits-1:0] wdata;
  } line_wr_t;

  typedef struct packed {
    logic wen;
    logic [itim_depth-1:0] waddr;
    logic [0:0] wdata;
  } lock_wr_t;

  // line set fetches a whole line, otherwise a single word.
  typedef struct packed {
    logic start;
    logic line;
    logic [31:0] addr;
  } fill_cmd_t;

  typedef struct packed {
    logic done;
    logic [31:0] word;
    logic [line_bits-1:0] line;
  } fill_rsp_t;

endpackage

// ==== src/itim_ram.sv ====
`timescale 1ns/100ps

module itim_ram
  import itim_pkg::*;
#(
  parameter int data_width = 1,
  parameter type wr_t = lock_wr_t
) (
  input  logic                  clk,
  input  wr_t                   wr,
  input  logic [itim_depth-1:0] raddr,
  output logic [data_width-1:0] rdata
);

  logic [data_width-1:0] mem [itim_lines] = '{default: '0};

  // a write to the line being read is forwarded, so a request taken in the
  // same cycle as an update sees the new contents.
  always_ff @(posedge clk) begin
    if (wr.wen) begin
      mem[wr.waddr] <= wr.wdata;
    end
    if (wr.wen && (wr.waddr == raddr)) begin
      rdata <= wr.wdata;
    end else begin
      rdata <= mem[raddr];
    end
  end

endmodule

// ==== verif/imem_model.sv ====
`timescale 1ns/100ps

module imem_model
  import itim_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  imem_req_t imem_req,
  output imem_rsp_t imem_rsp
);

  logic [15:0] lfsr = 16'd62583;
  logic [1:0] delay = '0;
  logic armed = 1'b0;
  imem_rsp_t rsp_q = '0;

  // galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hB400;
    end
    return state >> 1;
  endfunction

  // each word is its address times an odd constant xored with a fixed mask.
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return (addr * 32'h9E37_79B9) ^ 32'h5A5A_C3C3;
  endfunction

  assign imem_rsp = rsp_q;

  // each word waits 0 to 3 cycles drawn from two lfsr bits.
  always @(negedge clk) begin
    if (!rst) begin
      rsp_q <= '0;
      armed = 1'b0;
    end else if (rsp_q.ready) begin
      rsp_q.ready <= 1'b0;
      armed = 1'b0;
    end else if (imem_req.valid) begin
      if (!armed) begin
        delay[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        delay[1] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        armed = 1'b1;
      end
      if (delay == 2'd0) begin
        rsp_q.ready <= 1'b1;
        rsp_q.rdata <= word_at(imem_req.addr);
      end else begin
        delay = delay - 2'd1;
      end
    end
  end

endmodule

// ==== verif/itim_tb.sv ====
`timescale 1ns/100ps

module itim_tb
  import itim_pkg::*;
();

  localparam int reset_cycles = 5;
  localparam int n_requests = 18;
  localparam int fence_cycles = 16;
  localparam int watchdog_cycles = reset_cycles + n_requests * 40;

  // cycles of zero mean the answer time depends on the backing memory.
  typedef struct packed {
    logic fence;
    logic [31:0] data;
    logic [31:0] base;
    logic [2:0] reads;
    logic [4:0] cycles;
  } expect_t;

  logic clk = 1'b0;
  logic rst;
  fetch_req_t fetch_req;
  fetch_rsp_t fetch_rsp;
  imem_req_t imem_req;
  imem_rsp_t imem_rsp;

  expect_t next_exp = '0;
  expect_t cur_exp = '0;
  logic outstanding = 1'b0;
  int cyc = 0;
  int reads_seen = 0;
  int cycle = 0;
  int value_errors = 0;
  int timing_errors = 0;
  int backing_errors = 0;

  // reference copy of the tag and lock stores.
  logic [tag_bits-1:0] ref_tag [itim_lines];
  logic ref_lock [itim_lines];

  always #20 clk = ~clk;

  itim i_dut (
    .clk       (clk),
    .rst       (rst),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .imem_req  (imem_req),
    .imem_rsp  (imem_rsp)
  );

  imem_model i_imem (
    .clk      (clk),
    .rst      (rst),
    .imem_req (imem_req),
    .imem_rsp (imem_rsp)
  );

  // same rule as the memory model.
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B9) ^ 32'h5A5A_C3C3;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request tracking.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin
    cycle <= cycle + 1;
    cyc <= cyc + 1;
    if (imem_req.valid && imem_rsp.ready) begin
      reads_seen <= reads_seen + 1;
    end
    if (!rst) begin
      outstanding <= 1'b0;
    end else if (fetch_req.valid) begin
      outstanding <= 1'b1;
      cyc <= 1;
      reads_seen <= 0;
      cur_exp <= next_exp;
    end else if (fetch_rsp.ready) begin
      outstanding <= 1'b0;
    end
  end

  idle_quiet: assert property (@(posedge clk)
    ((cycle > 0) && (!rst || !outstanding)) |-> (!fetch_rsp.ready && !imem_req.valid))
  else begin
    timing_errors++;
    $display("fetch response or backing request seen with no fetch outstanding");
  end

  rdata_match: assert property (@(posedge clk)
    (fetch_rsp.ready && !cur_exp.fence) |-> (fetch_rsp.rdata == cur_exp.data))
  else begin
    value_errors++;
    $display("[ERROR] fetch_rsp.rdata = %h, expected %h",
             $sampled(fetch_rsp.rdata), $sampled(cur_exp.data));
  end

  ready_latency: assert property (@(posedge clk)
    (fetch_rsp.ready && (cur_exp.cycles != 0)) |-> (cyc == cur_exp.cycles))
  else begin
    timing_errors++;
    $display("fetch answered after %0d cycles instead of %0d",
             $sampled(cyc), $sampled(cur_exp.cycles));
  end

  read_count: assert property (@(posedge clk)
    fetch_rsp.ready |-> (reads_seen + int'(imem_req.valid && imem_rsp.ready) == cur_exp.reads))
  else begin
    backing_errors++;
    $display("fetch answered after %0d backing reads instead of %0d",
             $sampled(reads_seen) + int'($sampled(imem_req.valid && imem_rsp.ready)),
             $sampled(cur_exp.reads));
  end

  read_expected: assert property (@(posedge clk)
    ((cycle > 0) && imem_req.valid) |-> (reads_seen < cur_exp.reads))
  else begin
    backing_errors++;
    $display("backing memory request beyond the reads this fetch needs");
  end

  read_addr: assert property (@(posedge clk)
    (imem_req.valid && imem_rsp.ready) |->
      (imem_req.addr == cur_exp.base + 32'(4 * reads_seen)))
  else begin
    value_errors++;
    $display("[ERROR] imem_req.addr = %h, expected %h", $sampled(imem_req.addr),
             $sampled(cur_exp.base) + 32'(4 * $sampled(reads_seen)));
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic wait_ready();
    @(negedge clk);
    fetch_req.valid = 1'b0;
    fetch_req.fence = 1'b0;
    // an uncached answer lies between a falling and the next rising edge.
    while (outstanding && !fetch_rsp.ready) begin
      @(negedge clk);
    end
  endtask

  task automatic fetch_word(input logic [31:0] addr);
    itim_addr_t a;
    a.flat = addr;
    next_exp = '0;
    next_exp.data = expected_word(addr);
    if ((addr >= itim_base_addr) && (addr < itim_top_addr)) begin
      next_exp.base = addr & ~(32'(4 * words_per_line) - 32'd1);
      if (ref_lock[a.fields.index] && (ref_tag[a.fields.index] == a.fields.tag)) begin
        next_exp.cycles = 5'd1;
      end else begin
        next_exp.reads = 3'(words_per_line);
        ref_lock[a.fields.index] = 1'b1;
        ref_tag[a.fields.index] = a.fields.tag;
      end
    end else begin
      next_exp.base = addr;
      next_exp.reads = 3'd1;
    end
    fetch_req.valid = 1'b1;
    fetch_req.fence = 1'b0;
    fetch_req.addr = a;
    wait_ready();
  endtask

  task automatic fence_all();
    int i;
    next_exp = '0;
    next_exp.fence = 1'b1;
    next_exp.cycles = 5'(fence_cycles);
    for (i = 0; i < itim_lines; i++) begin
      ref_lock[i] = 1'b0;
    end
    fetch_req.valid = 1'b1;
    fetch_req.fence = 1'b1;
    wait_ready();
  endtask

  initial begin
    rst = 1'b0;
    fetch_req = '0;
    for (int i = 0; i < itim_lines; i++) begin
      ref_lock[i] = 1'b0;
      ref_tag[i] = '0;
    end
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b1;
    repeat (3) @(negedge clk);

    // cold misses, then back-to-back hits in the filled lines.
    fetch_word(32'h0000_1004);
    fetch_word(32'h0000_1008);
    fetch_word(32'h0000_100C);
    fetch_word(32'h0000_1000);
    fetch_word(32'h0000_1010);
    fetch_word(32'h0000_101C);

    // index 0 with another tag evicts the first line.
    fetch_word(32'h0000_1104);
    fetch_word(32'h0000_1004);
    fetch_word(32'h0000_1000);

    // outside the window, including the excluded top bound.
    fetch_word(32'h0000_0040);
    fetch_word(32'h0000_3008);
    fetch_word(32'h0000_2000);
    fetch_word(32'h0000_0FFC);
    fetch_word(32'h0000_0040);

    fence_all();
    fetch_word(32'h0000_1008);
    fetch_word(32'h0000_1014);
    fetch_word(32'h0000_1014);
    repeat (4) @(negedge clk);

    $display("errors: value %0d, timing %0d, backing %0d",
             value_errors, timing_errors, backing_errors);
    if ((value_errors + timing_errors + backing_errors) == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired with a fetch still unanswered");
    $display("Simulation FAILED");
    $finish;
  end

endmodule
